//--- common/soc_pkg.sv
// Shared bus types, address map and memory sizes for the SoC bus core.
// Addresses are byte addresses; all targets are word addressed (bits 1..0 ignored).
// Bit 31 splits main memory (0) from the I/O region (1).
// ROM_INIT_FILE is relative to the directory the simulator runs in.
package soc_pkg;

	// bus payload
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// 0 is the processor port, 1 the loader port
	typedef logic host_id_t;

	// targets inside the I/O region
	typedef enum logic [1:0] {
		io_rom,
		io_scratch,
		io_gpio,
		io_none
	} io_sel_t;

	// switches 1..0 sit above buttons 1..0
	typedef logic [3:0] gpio_in_t;
	typedef logic [3:0] led_t;

	// page code in address bits 15..12, byte offset in bits 11..0
	typedef logic [3:0] io_page_t;
	typedef logic [11:0] io_ofs_t;

	// address map
	localparam int MMIO_BASE_BIT = 31;

	localparam io_page_t IO_PAGE_ROM = 4'd0;
	localparam io_page_t IO_PAGE_SCRATCH = 4'd1;
	localparam io_page_t IO_PAGE_GPIO = 4'd2;

	localparam io_ofs_t GPIO_OFS_IN = 12'h000;
	localparam io_ofs_t GPIO_OFS_LED = 12'h004;

	// memory sizes, in words
	localparam int MAIN_WORDS_LOG2 = 12;
	localparam int ROM_WORDS_LOG2 = 4;
	localparam int SCRATCH_WORDS_LOG2 = 8;

	localparam string ROM_INIT_FILE = "mmio/bootrom.hex";

endpackage

//--- common/sys_bus_if.sv
// One access on the shared bus: strobe plus address and data from the master,
// read data and a one-cycle ready pulse from the slave.
// Only one of rd and we may be high in a cycle.
`timescale 1ns/1ps

interface sys_bus_if;
	import soc_pkg::*;

	addr_t a;
	data_t d;
	logic we;
	logic rd;
	data_t spo;
	logic ready;

	modport master (
		output a, d, we, rd,
		input spo, ready
	);

	modport slave (
		input a, d, we, rd,
		output spo, ready
	);

endinterface

//--- hdl/addr_router.sv
// Splits each access between main memory and the I/O region by address bit 31.
// Address and data go to both sides, the strobe only to the selected one.
// The response side is remembered for one cycle, which allows a new strobe
// in the same cycle as the previous ready.
`timescale 1ns/1ps

module addr_router (
	input logic clk_mem,
	input logic rst_n,
	sys_bus_if.slave sys,
	sys_bus_if.master mem,
	sys_bus_if.master io
);
	import soc_pkg::*;

	logic sel_io;
	logic resp_io;

	assign sel_io = sys.a[MMIO_BASE_BIT];

	assign mem.a = sys.a;
	assign mem.d = sys.d;
	assign mem.rd = sys.rd & ~sel_io;
	assign mem.we = sys.we & ~sel_io;

	assign io.a = sys.a;
	assign io.d = sys.d;
	assign io.rd = sys.rd & sel_io;
	assign io.we = sys.we & sel_io;

	// which side owns the response in the next cycle
	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			resp_io <= 1'b0;
		end else if (sys.rd || sys.we) begin
			resp_io <= sel_io;
		end
	end

	assign sys.spo = resp_io ? io.spo : mem.spo;
	assign sys.ready = resp_io ? io.ready : mem.ready;

	a_rd_we_exclusive: assert property (
		@(posedge clk_mem) disable iff (!rst_n)
		!(sys.rd && sys.we)
	);

	// both sides never answer in the same cycle
	a_one_side_ready: assert property (
		@(posedge clk_mem) disable iff (!rst_n)
		!(mem.ready && io.ready)
	);

endmodule

//--- hdl/bus_arbiter.sv
// Fixed-priority arbiter for two bus hosts, host 0 wins a tie.
// A grant lasts until its req falls; strobes of a host without grant are dropped.
// Read data is shared by both hosts, ready goes to the host that issued the strobe.
`timescale 1ns/1ps

module bus_arbiter (
	input logic clk_mem,
	input logic rst_n,
	input logic [1:0] req,
	output logic [1:0] gnt,
	input soc_pkg::addr_t [1:0] host_a,
	input soc_pkg::data_t [1:0] host_d,
	input logic [1:0] host_we,
	input logic [1:0] host_rd,
	output soc_pkg::data_t host_spo,
	output logic [1:0] host_ready,
	sys_bus_if.master sys
);
	import soc_pkg::*;

	logic busy;
	host_id_t owner;
	host_id_t resp_owner;
	logic strobe;

	// grant bookkeeping, one flop per host
	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			gnt <= 2'b00;
		end else if (!busy) begin
			if (req[0]) begin
				gnt <= 2'b01;
			end else if (req[1]) begin
				gnt <= 2'b10;
			end
		end else if (!req[owner]) begin
			// released, the other host can win on the next edge
			gnt <= 2'b00;
		end
	end

	assign busy = |gnt;
	assign owner = gnt[1];

	// forward the owner's access only
	assign sys.a = host_a[owner];
	assign sys.d = host_d[owner];
	assign sys.rd = busy & host_rd[owner];
	assign sys.we = busy & host_we[owner];

	assign strobe = sys.rd | sys.we;

	// grant may change under an access in flight
	always_ff @(posedge clk_mem) begin
		if (strobe) begin
			resp_owner <= owner;
		end
	end

	assign host_spo = sys.spo;
	assign host_ready = sys.ready ? (resp_owner ? 2'b10 : 2'b01) : 2'b00;

	a_single_grant: assert property (
		@(posedge clk_mem) disable iff (!rst_n)
		!(gnt[0] && gnt[1])
	);

	// every target below answers in exactly one cycle
	a_ready_latency: assert property (
		@(posedge clk_mem) disable iff (!rst_n)
		strobe |=> sys.ready
	);

	a_no_stray_ready: assert property (
		@(posedge clk_mem) disable iff (!rst_n)
		!strobe |=> !sys.ready
	);

endmodule

//--- hdl/main_ram.sv
// Word-addressed main memory, 4096 words, indexed by address bits 13..2.
// Higher address bits are ignored, so addresses alias every 16 KB.
// Contents are undefined after power-up and kept across reset.
// A read in the same cycle as a write to the same word returns the old word.
`timescale 1ns/1ps

module main_ram (
	input logic clk_mem,
	sys_bus_if.slave bus
);
	import soc_pkg::*;

	localparam int WORDS = 1 << MAIN_WORDS_LOG2;

	data_t mem_array [0:WORDS-1];
	logic [MAIN_WORDS_LOG2-1:0] word_idx;

	assign word_idx = bus.a[MAIN_WORDS_LOG2+1:2];

	always_ff @(posedge clk_mem) begin
		if (bus.we) begin
			mem_array[word_idx] <= bus.d;
		end
	end

	// registered read data, valid with ready
	always_ff @(posedge clk_mem) begin
		if (bus.rd) begin
			bus.spo <= mem_array[word_idx];
		end
	end

	// one ready pulse per strobe
	always_ff @(posedge clk_mem) begin
		bus.ready <= bus.rd | bus.we;
	end

endmodule

//--- hdl/soc_bus_top.sv
// Shared-memory core: two hosts, one arbitrated bus, main memory and I/O region.
// Host 0 is the processor port and wins ties, host 1 is the loader port.
// Each host keeps req high for all of its accesses; one cycle strobe to ready.
// Read data is common to both hosts and is valid only with that host's ready.
`timescale 1ns/1ps

module soc_bus_top (
	input logic clk_mem,
	input logic rst_n,
	input logic h0_req,
	input soc_pkg::addr_t h0_a,
	input soc_pkg::data_t h0_d,
	input logic h0_we,
	input logic h0_rd,
	output logic h0_gnt,
	output soc_pkg::data_t h0_spo,
	output logic h0_ready,
	input logic h1_req,
	input soc_pkg::addr_t h1_a,
	input soc_pkg::data_t h1_d,
	input logic h1_we,
	input logic h1_rd,
	output logic h1_gnt,
	output soc_pkg::data_t h1_spo,
	output logic h1_ready,
	input logic [1:0] sw,
	input logic [1:0] btn,
	output soc_pkg::led_t led
);

	soc_pkg::data_t host_spo;

	sys_bus_if sys_bus ();
	sys_bus_if mem_bus ();
	sys_bus_if io_bus ();

	// both hosts see the same read data
	assign h0_spo = host_spo;
	assign h1_spo = host_spo;

	bus_arbiter u_arbiter (
		.clk_mem (clk_mem),
		.rst_n (rst_n),
		.req ({h1_req, h0_req}),
		.gnt ({h1_gnt, h0_gnt}),
		.host_a ({h1_a, h0_a}),
		.host_d ({h1_d, h0_d}),
		.host_we ({h1_we, h0_we}),
		.host_rd ({h1_rd, h0_rd}),
		.host_spo (host_spo),
		.host_ready ({h1_ready, h0_ready}),
		.sys (sys_bus.master)
	);

	addr_router u_router (
		.clk_mem (clk_mem),
		.rst_n (rst_n),
		.sys (sys_bus.slave),
		.mem (mem_bus.master),
		.io (io_bus.master)
	);

	main_ram u_main_ram (
		.clk_mem (clk_mem),
		.bus (mem_bus.slave)
	);

	mmio_block u_mmio (
		.clk_mem (clk_mem),
		.rst_n (rst_n),
		.bus (io_bus.slave),
		.gpio_in ({sw, btn}),
		.led (led)
	);

endmodule

//--- mmio/bootrom.hex
// boot ROM image, one 32-bit hex word per line
// line n is ROM word n, at I/O page 0 byte offset 4*n
00000297
02028293
30529073
00001137
80000537
00050513
00100593
00b52023
0005a603
00c50663
ffdff06f
0000006f
13579bdf
2468ace0
a5a5c3c3
0f1e2d3c

//--- mmio/mmio_block.sv
// I/O region: boot ROM (16 words), scratch RAM (256 words) and GPIO registers.
// Page in address bits 15..12; other pages read as 0 and ignore writes.
// The ROM is loaded from ROM_INIT_FILE and is read-only.
// Scratch RAM and LED register keep their contents across reset; the LED
// outputs stay dark from reset until the first LED write.
`timescale 1ns/1ps

module mmio_block (
	input logic clk_mem,
	input logic rst_n,
	sys_bus_if.slave bus,
	input soc_pkg::gpio_in_t gpio_in,
	output soc_pkg::led_t led
);
	import soc_pkg::*;

	localparam int ROM_WORDS = 1 << ROM_WORDS_LOG2;
	localparam int SCRATCH_WORDS = 1 << SCRATCH_WORDS_LOG2;

	data_t rom [0:ROM_WORDS-1];
	data_t scratch [0:SCRATCH_WORDS-1];

	io_sel_t sel;
	io_ofs_t ofs;
	logic [ROM_WORDS_LOG2-1:0] rom_idx;
	logic [SCRATCH_WORDS_LOG2-1:0] scratch_idx;
	data_t gpio_rdata;
	logic led_wr;
	logic led_on;
	led_t led_q;

	initial begin
		$readmemh(ROM_INIT_FILE, rom);
	end

	// page decode
	always_comb begin
		case (bus.a[15:12])
			IO_PAGE_ROM: sel = io_rom;
			IO_PAGE_SCRATCH: sel = io_scratch;
			IO_PAGE_GPIO: sel = io_gpio;
			default: sel = io_none;
		endcase
	end

	assign ofs = bus.a[11:0];
	assign rom_idx = bus.a[ROM_WORDS_LOG2+1:2];
	assign scratch_idx = bus.a[SCRATCH_WORDS_LOG2+1:2];

	assign led_wr = bus.we && sel == io_gpio && ofs == GPIO_OFS_LED;
	assign led = led_on ? led_q : '0;

	// gpio read mux, inputs are read-only
	always_comb begin
		if (ofs == GPIO_OFS_IN) begin
			gpio_rdata = data_t'(gpio_in);
		end else if (ofs == GPIO_OFS_LED) begin
			gpio_rdata = data_t'(led);
		end else begin
			gpio_rdata = '0;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (bus.we && sel == io_scratch) begin
			scratch[scratch_idx] <= bus.d;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (led_wr) begin
			led_q <= bus.d[$bits(led_t)-1:0];
		end
	end

	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			led_on <= 1'b0;
		end else if (led_wr) begin
			led_on <= 1'b1;
		end
	end

	// read data and ready, one cycle after the strobe
	always_ff @(posedge clk_mem) begin
		if (bus.rd) begin
			case (sel)
				io_rom: bus.spo <= rom[rom_idx];
				io_scratch: bus.spo <= scratch[scratch_idx];
				io_gpio: bus.spo <= gpio_rdata;
				default: bus.spo <= '0;
			endcase
		end
		bus.ready <= bus.rd | bus.we;
	end

endmodule

//--- tests/tb_bus_tasks.svh
// Host driver tasks, compare tasks and reference memory model.
// Included inside the testbench module, after its signals, pend_* state and fail_run.
// Reads of main memory words that were never written are not modelled.
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

data_t ref_main [0:(1 << MAIN_WORDS_LOG2)-1];
data_t ref_rom [0:(1 << ROM_WORDS_LOG2)-1];
data_t ref_scratch [0:(1 << SCRATCH_WORDS_LOG2)-1];
led_t ref_led;
logic ref_led_set;

task automatic check_data(input string name, input data_t got, input data_t exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
	end
endtask

task automatic check_led(input string name, input led_t got, input led_t exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
	end
endtask

function automatic addr_t io_addr(input io_page_t page, input io_ofs_t ofs);
	return {1'b1, 15'd0, page, ofs};
endfunction

// expected read data from the address map
function automatic data_t model_read(input addr_t a);
	if (!a[MMIO_BASE_BIT]) begin
		return ref_main[a[MAIN_WORDS_LOG2+1:2]];
	end
	case (a[15:12])
		IO_PAGE_ROM: return ref_rom[a[ROM_WORDS_LOG2+1:2]];
		IO_PAGE_SCRATCH: return ref_scratch[a[SCRATCH_WORDS_LOG2+1:2]];
		IO_PAGE_GPIO: begin
			if (a[11:0] == GPIO_OFS_IN) begin
				return {28'd0, sw, btn};
			end else if (a[11:0] == GPIO_OFS_LED) begin
				return ref_led_set ? {28'd0, ref_led} : '0;
			end
			return '0;
		end
		default: return '0;
	endcase
endfunction

// rom and unmapped pages ignore writes
task automatic model_write(input addr_t a, input data_t d);
	if (!a[MMIO_BASE_BIT]) begin
		ref_main[a[MAIN_WORDS_LOG2+1:2]] = d;
	end else if (a[15:12] == IO_PAGE_SCRATCH) begin
		ref_scratch[a[SCRATCH_WORDS_LOG2+1:2]] = d;
	end else if (a[15:12] == IO_PAGE_GPIO && a[11:0] == GPIO_OFS_LED) begin
		ref_led = d[3:0];
		ref_led_set = 1'b1;
	end
endtask

task automatic drive_host(input host_id_t h, input logic we, input addr_t a, input data_t d);
	if (h == 1'b0) begin
		h0_we = we;
		h0_rd = !we;
		h0_a = a;
		h0_d = d;
	end else begin
		h1_we = we;
		h1_rd = !we;
		h1_a = a;
		h1_d = d;
	end
endtask

// one clock, then check the response to the strobe of the last cycle
task automatic tick();
	@(posedge clk_mem);
	#2;
	check_flag("h0_ready", h0_ready, pend_valid && pend_host == 1'b0);
	check_flag("h1_ready", h1_ready, pend_valid && pend_host == 1'b1);
	if (pend_valid && pend_rd) begin
		if (pend_host == 1'b0) begin
			check_data("h0_spo", h0_spo, pend_exp);
		end else begin
			check_data("h1_spo", h1_spo, pend_exp);
		end
	end
	pend_valid = 1'b0;
	h0_we = 1'b0;
	h0_rd = 1'b0;
	h1_we = 1'b0;
	h1_rd = 1'b0;
endtask

task automatic strobe(input host_id_t h, input logic we, input addr_t a, input data_t d);
	pend_valid = 1'b1;
	pend_host = h;
	pend_rd = !we;
	if (we) begin
		model_write(a, d);
	end else begin
		pend_exp = model_read(a);
	end
	drive_host(h, we, a, d);
	tick();
endtask

task automatic acquire_bus(input host_id_t h);
	int n;
	n = 0;
	if (h == 1'b0) begin
		h0_req = 1'b1;
	end else begin
		h1_req = 1'b1;
	end
	do begin
		tick();
		n++;
		if (n > GNT_WAIT) begin
			fail_run($sformatf("host %0d never received a grant", h));
		end
	end while ((h == 1'b0) ? !h0_gnt : !h1_gnt);
endtask

task automatic release_bus(input host_id_t h);
	if (h == 1'b0) begin
		h0_req = 1'b0;
	end else begin
		h1_req = 1'b0;
	end
	tick();
	check_flag("h0_gnt", h0_gnt, 1'b0);
	check_flag("h1_gnt", h1_gnt, 1'b0);
endtask

`endif

//--- tests/tb_soc_bus.sv
// Directed testbench for the shared bus core; it plays both hosts.
// Expects to run from the project root so that mmio/bootrom.hex is found.
// Stops at the first mismatch; a watchdog bounds the run time.
`timescale 1ns/1ps

module tb_soc_bus;
	import soc_pkg::*;

	localparam int CLK_NS = 20;
	localparam int NUM_TESTS = 6;
	localparam int WORST_CYCLES = 300;
	localparam int WATCHDOG_NS = 2 * (NUM_TESTS * WORST_CYCLES + 10) * CLK_NS;
	localparam int GNT_WAIT = 20;
	localparam string ROM_IMAGE = "mmio/bootrom.hex";

	logic clk_mem;
	logic rst_n;
	logic h0_req, h0_we, h0_rd, h0_gnt, h0_ready;
	logic h1_req, h1_we, h1_rd, h1_gnt, h1_ready;
	addr_t h0_a, h1_a;
	data_t h0_d, h1_d, h0_spo, h1_spo;
	logic [1:0] sw;
	logic [1:0] btn;
	led_t led;

	// strobe waiting for its ready
	logic pend_valid;
	host_id_t pend_host;
	logic pend_rd;
	data_t pend_exp;
	logic [15:0] lfsr_state;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_bus_tasks.svh"

	soc_bus_top DUT (
		.clk_mem (clk_mem), .rst_n (rst_n),
		.h0_req (h0_req), .h0_a (h0_a), .h0_d (h0_d), .h0_we (h0_we), .h0_rd (h0_rd),
		.h0_gnt (h0_gnt), .h0_spo (h0_spo), .h0_ready (h0_ready),
		.h1_req (h1_req), .h1_a (h1_a), .h1_d (h1_d), .h1_we (h1_we), .h1_rd (h1_rd),
		.h1_gnt (h1_gnt), .h1_spo (h1_spo), .h1_ready (h1_ready),
		.sw (sw), .btn (btn), .led (led)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic data_t rand_bits(input int n);
		data_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic test_reset_grant();
		check_flag("h0_gnt", h0_gnt, 1'b0);
		check_flag("h1_gnt", h1_gnt, 1'b0);
		check_flag("h0_ready", h0_ready, 1'b0);
		check_flag("h1_ready", h1_ready, 1'b0);
		check_led("led", led, '0);
		h0_req = 1'b1;
		tick();
		check_flag("h0_gnt", h0_gnt, 1'b1);
		check_flag("h1_gnt", h1_gnt, 1'b0);
		release_bus(1'b0);
		h1_req = 1'b1;
		tick();
		check_flag("h1_gnt", h1_gnt, 1'b1);
		check_flag("h0_gnt", h0_gnt, 1'b0);
		release_bus(1'b1);
	endtask

	task automatic test_main_memory();
		addr_t addrs [16];
		addr_t a;
		acquire_bus(1'b0);
		for (int i = 0; i < 16; i++) begin
			a = rand_bits(31);
			a[1:0] = 2'b00;
			addrs[i] = a;
			strobe(1'b0, 1'b1, a, rand_bits(32));
		end
		for (int i = 0; i < 16; i++) begin
			strobe(1'b0, 1'b0, addrs[i], '0);
		end
		// same word seen through bits above 13
		a = addrs[0] ^ 32'h2000_4000;
		strobe(1'b0, 1'b0, a, '0);
		strobe(1'b0, 1'b1, a, rand_bits(32));
		strobe(1'b0, 1'b0, addrs[0], '0);
		release_bus(1'b0);
	endtask

	task automatic test_io_region();
		io_ofs_t ofs [8];
		acquire_bus(1'b0);
		for (int i = 0; i < 16; i++) begin
			strobe(1'b0, 1'b0, io_addr(IO_PAGE_ROM, io_ofs_t'(i * 4)), '0);
		end
		strobe(1'b0, 1'b1, io_addr(IO_PAGE_ROM, 12'h00c), 32'hdead_beef);
		strobe(1'b0, 1'b0, io_addr(IO_PAGE_ROM, 12'h00c), '0);
		for (int i = 0; i < 8; i++) begin
			ofs[i] = io_ofs_t'(rand_bits(10)) & 12'h3fc;
			strobe(1'b0, 1'b1, io_addr(IO_PAGE_SCRATCH, ofs[i]), rand_bits(32));
		end
		for (int i = 0; i < 8; i++) begin
			strobe(1'b0, 1'b0, io_addr(IO_PAGE_SCRATCH, ofs[i]), '0);
		end
		strobe(1'b0, 1'b1, io_addr(4'd5, 12'h010), 32'h1111_2222);
		strobe(1'b0, 1'b0, io_addr(4'd5, 12'h010), '0);
		strobe(1'b0, 1'b0, io_addr(4'hf, 12'h000), '0);
		release_bus(1'b0);
	endtask

	task automatic test_gpio();
		acquire_bus(1'b0);
		sw = 2'b10;
		btn = 2'b01;
		strobe(1'b0, 1'b0, io_addr(IO_PAGE_GPIO, GPIO_OFS_IN), '0);
		sw = 2'b01;
		btn = 2'b11;
		strobe(1'b0, 1'b0, io_addr(IO_PAGE_GPIO, GPIO_OFS_IN), '0);
		strobe(1'b0, 1'b1, io_addr(IO_PAGE_GPIO, GPIO_OFS_LED), 32'h1234_567a);
		check_led("led", led, 4'ha);
		strobe(1'b0, 1'b0, io_addr(IO_PAGE_GPIO, GPIO_OFS_LED), '0);
		strobe(1'b0, 1'b0, io_addr(IO_PAGE_GPIO, 12'h008), '0);
		release_bus(1'b0);
	endtask

	task automatic test_arbitration();
		addr_t a;
		data_t d;
		a = rand_bits(31);
		a[1:0] = 2'b00;
		d = rand_bits(32);
		h0_req = 1'b1;
		h1_req = 1'b1;
		tick();
		check_flag("h0_gnt", h0_gnt, 1'b1);
		check_flag("h1_gnt", h1_gnt, 1'b0);
		strobe(1'b0, 1'b1, a, d);
		// host 1 has no grant, this write must be dropped
		drive_host(1'b1, 1'b1, a, ~d);
		tick();
		check_flag("h1_gnt", h1_gnt, 1'b0);
		h0_req = 1'b0;
		tick();
		check_flag("h0_gnt", h0_gnt, 1'b0);
		check_flag("h1_gnt", h1_gnt, 1'b0);
		tick();
		check_flag("h1_gnt", h1_gnt, 1'b1);
		strobe(1'b1, 1'b0, a, '0);
		release_bus(1'b1);
	endtask

	task automatic test_back_to_back();
		addr_t a;
		a = rand_bits(31);
		a[1:0] = 2'b00;
		acquire_bus(1'b1);
		strobe(1'b1, 1'b1, a, rand_bits(32));
		strobe(1'b1, 1'b1, io_addr(IO_PAGE_SCRATCH, 12'h040), rand_bits(32));
		strobe(1'b1, 1'b0, a, '0);
		strobe(1'b1, 1'b0, io_addr(IO_PAGE_SCRATCH, 12'h040), '0);
		strobe(1'b1, 1'b0, io_addr(IO_PAGE_ROM, 12'h008), '0);
		strobe(1'b1, 1'b1, io_addr(IO_PAGE_GPIO, GPIO_OFS_LED), 32'h0000_0005);
		strobe(1'b1, 1'b0, io_addr(IO_PAGE_GPIO, GPIO_OFS_LED), '0);
		strobe(1'b1, 1'b0, a, '0);
		check_led("led", led, 4'h5);
		tick();
		release_bus(1'b1);
	endtask

	initial begin
		clk_mem = 1'b0;
		forever #(CLK_NS / 2) clk_mem = ~clk_mem;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the tests finished");
	end

	initial begin
		rst_n = 1'b0;
		h0_req = 1'b0;
		h1_req = 1'b0;
		drive_host(1'b0, 1'b0, '0, '0);
		drive_host(1'b1, 1'b0, '0, '0);
		h0_rd = 1'b0;
		h1_rd = 1'b0;
		sw = 2'b00;
		btn = 2'b00;
		pend_valid = 1'b0;
		pend_host = 1'b0;
		pend_rd = 1'b0;
		pend_exp = '0;
		lfsr_state = 16'd67;
		ref_led = '0;
		ref_led_set = 1'b0;
		$readmemh(ROM_IMAGE, ref_rom);
		if ($isunknown(ref_rom[(1 << ROM_WORDS_LOG2) - 1])) begin
			fail_run("boot ROM image could not be loaded");
		end
		repeat (10) @(posedge clk_mem);
		#2;
		rst_n = 1'b1;
		test_reset_grant();
		test_main_memory();
		test_io_region();
		test_gpio();
		test_arbitration();
		test_back_to_back();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+tests
common/soc_pkg.sv
common/sys_bus_if.sv
hdl/bus_arbiter.sv
hdl/addr_router.sv
hdl/main_ram.sv
mmio/mmio_block.sv
hdl/soc_bus_top.sv
tests/tb_soc_bus.sv
